// File: bench/lmg_cases.txt
// word 0: number of cases
// each case: header {side in bit 8, move count in bits 7:0}, rows 0 to 7
// (column a in the low nibble), then the expected moves {capture, from, to}
6
// black king alone on h8, black to move
103 00000000 00000000 00000000 00000000 00000000 00000000 00000000 E0000000
FF7 FF6 FFE
// white king alone on d4
008 00000000 00000000 00000000 00006000 00000000 00000000 00000000 00000000
6E3 6E4 6DC 6D4 6D3 6D2 6DA 6E2
// white knight on c3, own pawns on b1 and e4, black pawns on a2 and d5
006 00000010 00000009 00000200 00010000 00009000 00000000 00000000 00000000
14A3 048C 0483 1488 0498 04A1
// black king and knight only, white to move
000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 000E00A0
// empty board
000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
// white king c6 and knight c3, knights on f4, g3 and e7
023 00000000 00000000 02000200 00200000 00000000 00000600 00020000 00000000
4A3 49C 48C 483 481 488 498 4A1 AB2 AB3 AAB AA3 AA2 AA1 AA9 AB1
76E 767 757 74E 74C 753 763 76C 5A7 587 585 58C 59C 5A5
D3E D2E D25 D23 D3A

// File: project.f
source/lmg_pkg.sv
source/square_stepper.sv
source/move_fifo.sv
source/column_move_gen.sv
source/drain_fsm.sv
source/lmg.sv
bench/lmg_checker.sv
bench/lmg_tb.sv

// File: Makefile
# Verilator flow for the move generator
VERILATOR  ?= verilator
TOP        ?= lmg_tb
RTL_TOP    ?= lmg
FILELIST   ?= project.f
RTL_FILES  ?= $(shell grep '^source/' $(FILELIST))
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only -Wall
SIM_FLAGS  ?= --binary -Wno-fatal
PASS_TEXT  ?= *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

# pass or fail comes from the log, not from the simulator's exit status
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qF '$(PASS_TEXT)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/lmg_tb.sv
`default_nettype none

module lmg_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import lmg_pkg::*;

	localparam string       cases_file    = "bench/lmg_cases.txt";
	localparam int          drain_timeout = 2000;
	localparam logic [31:0] lfsr_seed     = 32'h9fc795f0;

	logic                   clk;
	logic                   reset;
	logic [board_width-1:0] bstate;
	logic                   side;
	logic                   rden;
	move_t                  move_out;
	logic                   move_valid;
	logic                   done;

	logic [31:0]       cases_mem [512];
	logic [63:0][12:0] exp_list;
	logic [6:0]        exp_count;
	logic              case_end;
	int                case_num;
	int                cases_passed;
	int                cases_failed;
	int                error_count;
	int                ptr;
	logic [31:0]       lfsr;
	logic              timed_out;

	lmg i_lmg (
		.clk        (clk),
		.reset      (reset),
		.bstate     (bstate),
		.side       (side),
		.rden       (rden),
		.move_out   (move_out),
		.move_valid (move_valid),
		.done       (done)
	);

	lmg_checker i_checker (
		.clk          (clk),
		.reset        (reset),
		.rden         (rden),
		.move_out     (move_out),
		.move_valid   (move_valid),
		.done         (done),
		.exp_list     (exp_list),
		.exp_count    (exp_count),
		.case_end     (case_end),
		.case_num     (case_num),
		.cases_passed (cases_passed),
		.cases_failed (cases_failed),
		.error_count  (error_count)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic next_bit(output logic b);
		b    = lfsr[31];
		lfsr = lfsr_step(lfsr);
	endtask

	// header, eight row words, then the expected moves
	task automatic load_case();
		logic [31:0] header;
		int          count;
		header = cases_mem[ptr];
		ptr++;
		side  = header[8];
		count = int'(header[7:0]);
		for (int r = 0; r < 8; r++) begin
			bstate[r*32 +: 32] = cases_mem[ptr];
			ptr++;
		end
		exp_list = '0;
		for (int m = 0; m < count; m++) begin
			exp_list[m] = cases_mem[ptr][12:0];
			ptr++;
		end
		exp_count = 7'(count);
	endtask

	task automatic run_case();
		logic b0;
		logic b1;
		logic b2;
		int   waited;
		@(posedge clk);
		#1;
		load_case();
		reset = 1'b1;
		rden  = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		reset  = 1'b0;
		waited = 0;
		// rden high about one cycle in eight, so the output FIFO fills
		while (!(done && !move_valid) && waited < drain_timeout) begin
			@(posedge clk);
			#1;
			next_bit(b0);
			next_bit(b1);
			next_bit(b2);
			rden = b0 && b1 && b2;
			waited++;
		end
		rden = 1'b0;
		if (!(done && !move_valid)) begin
			$display("case %0d: done with an empty output FIFO not seen after %0d cycles",
				case_num, drain_timeout);
			timed_out = 1'b1;
		end
		case_end = 1'b1;
		@(posedge clk);
		#1;
		case_end = 1'b0;
	endtask

	initial begin
		int num_cases;
		reset     = 1'b1;
		bstate    = '0;
		side      = 1'b0;
		rden      = 1'b0;
		exp_list  = '0;
		exp_count = '0;
		case_end  = 1'b0;
		case_num  = 0;
		ptr       = 1;
		lfsr      = lfsr_seed;
		timed_out = 1'b0;
		$readmemh(cases_file, cases_mem);
		num_cases = int'(cases_mem[0]);
		if (num_cases < 1)
			$display("no cases found in %s", cases_file);
		for (int n = 1; n <= num_cases && !timed_out; n++) begin
			case_num = n;
			run_case();
		end
		$display("cases %0d, passed %0d, failed %0d, errors %0d",
			num_cases, cases_passed, cases_failed, error_count);
		if (num_cases > 0 && !timed_out && cases_failed == 0 && error_count == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/lmg_checker.sv
`default_nettype none

module lmg_checker (
	input  logic              clk,
	input  logic              reset,
	input  logic              rden,
	input  lmg_pkg::move_t    move_out,
	input  logic              move_valid,
	input  logic              done,
	input  logic [63:0][12:0] exp_list,
	input  logic [6:0]        exp_count,
	input  logic              case_end,
	input  int                case_num,
	output int                cases_passed,
	output int                cases_failed,
	output int                error_count
);

	timeunit 1ns;
	timeprecision 100ps;

	import lmg_pkg::*;

	logic [63:0] seen        = '0;
	logic        reset_q     = 1'b0;
	logic        done_q      = 1'b0;
	logic        hold_q      = 1'b0;
	move_t       word_q      = '0;
	int          case_errors = 0;
	int          passed_n    = 0;
	int          failed_n    = 0;
	int          errors_n    = 0;

	assign cases_passed = passed_n;
	assign cases_failed = failed_n;
	assign error_count  = errors_n;

	task automatic report_mismatch(input string name, input logic [12:0] got,
			input logic [12:0] expected);
		$display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, expected);
		case_errors++;
		errors_n++;
	endtask

	task automatic report_problem(input string what);
		$display("error at %0t ns: %s", $time, what);
		case_errors++;
		errors_n++;
	endtask

	// expected list is a set, each entry taken once
	task automatic take_word(input move_t w);
		int   hit;
		logic again;
		hit   = -1;
		again = 1'b0;
		for (int i = 0; i < int'(exp_count); i++) begin
			if (exp_list[i] == w) begin
				if (!seen[i] && hit < 0)
					hit = i;
				else if (seen[i])
					again = 1'b1;
			end
		end
		if (hit >= 0)
			seen[hit] = 1'b1;
		else if (again)
			report_problem($sformatf("move %h read twice", w));
		else
			report_problem($sformatf("move %h read but not expected", w));
	endtask

	task automatic finish_case();
		for (int i = 0; i < int'(exp_count); i++) begin
			if (!seen[i])
				report_problem($sformatf("move %h never read", exp_list[i]));
		end
		if (case_errors == 0) begin
			passed_n++;
			$display("case %0d ok, %0d moves", case_num, exp_count);
		end else begin
			failed_n++;
			$display("case %0d failed, %0d errors", case_num, case_errors);
		end
	endtask

	// sample outputs on the falling edge
	always @(negedge clk) begin
		if (reset) begin
			if (!reset_q) begin
				seen        = '0;
				case_errors = 0;
			end else begin
				if (done)
					report_mismatch("done", 13'(done), 13'd0);
				if (move_valid)
					report_mismatch("move_valid", 13'(move_valid), 13'd0);
			end
			done_q = 1'b0;
			hold_q = 1'b0;
		end else begin
			if (done_q && !done)
				report_mismatch("done", 13'(done), 13'd1);
			// unread head word stays put
			if (hold_q && !move_valid)
				report_mismatch("move_valid", 13'd0, 13'd1);
			else if (hold_q && move_out != word_q)
				report_mismatch("move_out", move_out, word_q);
			if (rden && move_valid)
				take_word(move_out);
			if (case_end)
				finish_case();
			done_q = done;
			hold_q = move_valid && !rden;
			word_q = move_out;
		end
		reset_q = reset;
	end

endmodule

`default_nettype wire

// File: source/lmg.sv
`default_nettype none

module lmg #(
	parameter int col_fifo_depth = 16,
	parameter int out_fifo_depth = 32,
	parameter int num_cols       = 8
) (
	input  logic                            clk,
	input  logic                            reset,
	input  logic [lmg_pkg::board_width-1:0] bstate,
	input  logic                            side,
	input  logic                            rden,
	output lmg_pkg::move_t                  move_out,
	output logic                            move_valid,
	output logic                            done
);

	import lmg_pkg::*;

	move_t               col_moves [num_cols];
	logic [num_cols-1:0] col_empty;
	logic [num_cols-1:0] col_done;
	logic [num_cols-1:0] col_rden;
	logic [2:0]          col_sel;
	logic                out_wren;
	logic                out_full;
	logic                out_empty;
	move_t               out_wr_data;

	// one unit per file with column a at index 0
	for (genvar c = 0; c < num_cols; c++) begin : g_col
		column_move_gen #(
			.col_index      (c),
			.col_fifo_depth (col_fifo_depth)
		) i_col (
			.clk       (clk),
			.reset     (reset),
			.bstate    (bstate),
			.side      (side),
			.col_rden  (col_rden[c]),
			.col_move  (col_moves[c]),
			.col_empty (col_empty[c]),
			.col_done  (col_done[c])
		);
	end

	drain_fsm #(
		.num_cols (num_cols)
	) i_drain (
		.clk       (clk),
		.reset     (reset),
		.col_done  (col_done),
		.col_empty (col_empty),
		.out_full  (out_full),
		.col_rden  (col_rden),
		.col_sel   (col_sel),
		.out_wren  (out_wren),
		.done      (done)
	);

	assign out_wr_data = col_moves[col_sel];

	move_fifo #(
		.depth (out_fifo_depth)
	) i_out_fifo (
		.clk     (clk),
		.reset   (reset),
		.wr_data (out_wr_data),
		.wren    (out_wren),
		.rden    (rden && move_valid),
		.rd_data (move_out),
		.full    (out_full),
		.empty   (out_empty)
	);

	assign move_valid = !out_empty;

endmodule

`default_nettype wire

// File: source/drain_fsm.sv
`default_nettype none

module drain_fsm #(
	parameter int num_cols = 8
) (
	input  logic                clk,
	input  logic                reset,
	input  logic [num_cols-1:0] col_done,
	input  logic [num_cols-1:0] col_empty,
	input  logic                out_full,
	output logic [num_cols-1:0] col_rden,
	output logic [2:0]          col_sel,
	output logic                out_wren,
	output logic                done
);

	import lmg_pkg::*;

	drain_state_t state;

	logic [num_cols-1:0] moved;
	logic [num_cols-1:0] ready;
	logic [2:0]          col_ptr;
	logic [2:0]          pick;
	logic                pick_any;
	logic                xfer;

	// done, not yet copied and holding moves
	assign ready = col_done & ~moved & ~col_empty;

	// highest index wins
	always_comb begin
		pick     = 3'd0;
		pick_any = 1'b0;
		for (int i = 0; i < num_cols; i++) begin
			if (ready[i]) begin
				pick     = 3'(i);
				pick_any = 1'b1;
			end
		end
	end

	assign xfer     = (state == getm_s) && !col_empty[col_ptr] && !out_full;
	assign out_wren = xfer;
	assign col_rden = xfer ? (num_cols'(1) << col_ptr) : '0;
	assign col_sel  = col_ptr;
	assign done     = (state == done_s);

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= wait_s;
			moved   <= '0;
			col_ptr <= 3'd0;
		end else begin
			case (state)
				wait_s: begin
					// finished columns with nothing to copy
					moved <= moved | (col_done & col_empty);
					if (&moved) begin
						state <= done_s;
					end else if (pick_any) begin
						state   <= getm_s;
						col_ptr <= pick;
					end
				end
				getm_s: begin
					if (col_empty[col_ptr]) begin
						state          <= wait_s;
						moved[col_ptr] <= 1'b1;
					end
				end
				default: state <= done_s;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/column_move_gen.sv
`default_nettype none

module column_move_gen #(
	parameter int col_index      = 0,
	parameter int col_fifo_depth = 16
) (
	input  logic                               clk,
	input  logic                               reset,
	input  logic [lmg_pkg::board_width-1:0]    bstate,
	input  logic                               side,
	input  logic                               col_rden,
	output lmg_pkg::move_t                     col_move,
	output logic                               col_empty,
	output logic                               col_done
);

	import lmg_pkg::*;

	logic [2:0] row;
	logic [2:0] offset;
	logic       at_offset;
	logic       finished;
	logic       fifo_full;
	logic       hold;

	square_t cur_sq;
	piece_t  cur_piece;
	logic    is_knight;
	logic    is_king;
	logic    piece_active;

	logic signed [2:0] drow;
	logic signed [2:0] dcol;
	logic signed [4:0] t_row;
	logic signed [4:0] t_col;
	logic              on_board;
	square_t           t_sq;
	piece_t            t_piece;
	logic              t_empty;
	logic              t_friend;
	logic              legal;
	logic              wren;
	move_t             new_move;

	// current square of this file
	assign cur_sq    = {row, 3'(col_index)};
	assign cur_piece = bstate[{cur_sq, 2'b00} +: square_bits];

	assign is_knight    = (cur_piece[2:0] == piece_knight);
	assign is_king      = (cur_piece[2:0] == piece_king);
	assign piece_active = (cur_piece[3] == side) && (is_knight || is_king);

	always_comb begin
		if (is_knight) begin
			drow = knight_offsets[offset][0];
			dcol = knight_offsets[offset][1];
		end else begin
			drow = king_offsets[offset][0];
			dcol = king_offsets[offset][1];
		end
		t_row = $signed({2'b00, row}) + drow;
		t_col = $signed({2'b00, 3'(col_index)}) + dcol;
	end

	// negative or past 7 shows up in the top two bits
	assign on_board = (t_row[4:3] == 2'b00) && (t_col[4:3] == 2'b00);

	assign t_sq     = {t_row[2:0], t_col[2:0]};
	assign t_piece  = bstate[{t_sq, 2'b00} +: square_bits];
	assign t_empty  = (t_piece[2:0] == piece_empty);
	assign t_friend = !t_empty && (t_piece[3] == side);

	assign legal = at_offset && on_board && !t_friend;

	// stall the offset while a legal move cannot be stored
	assign hold = legal && fifo_full;
	assign wren = legal && !fifo_full;

	assign new_move.capture = !t_empty;
	assign new_move.from_sq = cur_sq;
	assign new_move.to_sq   = t_sq;

	assign col_done = finished;

	square_stepper i_stepper (
		.clk          (clk),
		.reset        (reset),
		.hold         (hold),
		.piece_active (piece_active),
		.row          (row),
		.offset       (offset),
		.at_offset    (at_offset),
		.finished     (finished)
	);

	move_fifo #(
		.depth (col_fifo_depth)
	) i_col_fifo (
		.clk     (clk),
		.reset   (reset),
		.wr_data (new_move),
		.wren    (wren),
		.rden    (col_rden),
		.rd_data (col_move),
		.full    (fifo_full),
		.empty   (col_empty)
	);

endmodule

`default_nettype wire

// File: source/move_fifo.sv
`default_nettype none

module move_fifo #(
	parameter int depth = 16
) (
	input  logic           clk,
	input  logic           reset,
	input  lmg_pkg::move_t wr_data,
	input  logic           wren,
	input  logic           rden,
	output lmg_pkg::move_t rd_data,
	output logic           full,
	output logic           empty
);

	import lmg_pkg::*;

	localparam int ptr_w   = (depth > 1) ? $clog2(depth) : 1;
	localparam int count_w = $clog2(depth + 1);

	move_t mem [depth];

	logic [ptr_w-1:0]   wr_ptr;
	logic [ptr_w-1:0]   rd_ptr;
	logic [count_w-1:0] count;
	logic               do_wr;
	logic               do_rd;

	assign full  = (count == count_w'(depth));
	assign empty = (count == '0);

	assign do_wr = wren && !full;
	assign do_rd = rden && !empty;

	// head word with no read latency
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;

			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: source/square_stepper.sv
`default_nettype none

module square_stepper (
	input  logic       clk,
	input  logic       reset,
	input  logic       hold,
	input  logic       piece_active,
	output logic [2:0] row,
	output logic [2:0] offset,
	output logic       at_offset,
	output logic       finished
);

	logic row_step;
	logic offset_step;

	// empty squares pass in one cycle, active ones after the last offset
	assign offset_step = !finished && piece_active && !hold;
	assign row_step    = !finished && (!piece_active || (offset_step && offset == 3'd7));

	assign at_offset = piece_active && !finished;

	always_ff @(posedge clk) begin
		if (reset) begin
			row      <= 3'd0;
			offset   <= 3'd0;
			finished <= 1'b0;
		end else begin
			// wraps back to 0 on the row step
			if (offset_step)
				offset <= offset + 3'd1;

			if (row_step) begin
				if (row == 3'd7)
					finished <= 1'b1;
				else
					row <= row + 3'd1;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/lmg_pkg.sv
`default_nettype none

package lmg_pkg;

	parameter int square_bits = 4;
	parameter int num_squares = 64;
	parameter int board_width = num_squares * square_bits;

	// bit 3 is colour (1 = black), bits 2..0 the piece type
	typedef logic [square_bits-1:0] piece_t;

	parameter logic [2:0] piece_empty  = 3'd0;
	parameter logic [2:0] piece_knight = 3'd2;
	parameter logic [2:0] piece_king   = 3'd6;

	// row * 8 + column
	typedef logic [5:0] square_t;

	typedef struct packed {
		logic    capture;
		square_t from_sq;
		square_t to_sq;
	} move_t;

	typedef enum logic [1:0] {
		wait_s = 2'b01,
		getm_s = 2'b11,
		done_s = 2'b10
	} drain_state_t;

	// (row delta, column delta) per offset step
	parameter logic signed [2:0] knight_offsets [8][2] = '{
		'{ 3'sd2,  3'sd1},
		'{ 3'sd1,  3'sd2},
		'{-3'sd1,  3'sd2},
		'{-3'sd2,  3'sd1},
		'{-3'sd2, -3'sd1},
		'{-3'sd1, -3'sd2},
		'{ 3'sd1, -3'sd2},
		'{ 3'sd2, -3'sd1}
	};

	parameter logic signed [2:0] king_offsets [8][2] = '{
		'{ 3'sd1,  3'sd0},
		'{ 3'sd1,  3'sd1},
		'{ 3'sd0,  3'sd1},
		'{-3'sd1,  3'sd1},
		'{-3'sd1,  3'sd0},
		'{-3'sd1, -3'sd1},
		'{ 3'sd0, -3'sd1},
		'{ 3'sd1, -3'sd1}
	};

endpackage

`default_nettype wire
